/* common/isa_pkg.sv */
package isa_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

    // major opcodes used by the sequencer
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;   // M extension on OP

    // J-type, immediate bits scattered over the upper 20 bits
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // R/I/B share the funct7/rs2/rs1/funct3 layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } ib_fmt_t;

    typedef union packed {
        j_fmt_t  j_fmt;
        ib_fmt_t ib_fmt;
    } instr_word_u;

    typedef enum logic [2:0] {PLAIN, JAL, JALR, BRANCH, MULDIV} instr_class_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } issue_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;   // jalr or branch destination
    } resolve_t;

endpackage

/* common/mem_pkg.sv */
package mem_pkg;

    localparam int MEM_AW    = 8;               // word address bits
    localparam int MEM_DEPTH = 1 << MEM_AW;

    // instruction memory sits at the reset vector
    localparam logic [isa_pkg::XLEN-1:0] MEM_BASE = isa_pkg::RESET_PC;

    typedef struct packed {
        logic                     we;
        logic [MEM_AW-1:0]        addr;   // word address
        logic [isa_pkg::XLEN-1:0] wdata;
    } mem_req_t;

endpackage

/* design/sram_model.sv */
`timescale 1ns/100ps

module sram_model (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t mem_req,
    input  logic              mem_en,
    output logic [31:0]       rdata
);

    logic [31:0] mem [mem_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (mem_en && mem_req.we) begin
            mem[mem_req.addr] <= mem_req.wdata;
        end
    end

    // read port, holds last word until the next read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (mem_en && !mem_req.we) begin
            rdata <= mem[mem_req.addr];
        end
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      ld_req,
    input  mem_pkg::mem_req_t         ld_cmd,
    output logic                      ld_ack,
    input  logic                      f_req,
    input  logic [mem_pkg::MEM_AW-1:0] f_addr,
    output logic                      f_ack,
    output logic [31:0]               f_rdata,
    output mem_pkg::mem_req_t         mem_req,
    output logic                      mem_en,
    input  logic [31:0]               rdata
);

    typedef enum logic [1:0] {IDLE, LD_GRANT, F_GRANT} grant_e;
    typedef enum logic [1:0] {ISSUE, RESP, RELEASE} phase_e;

    grant_e grant;
    phase_e phase;
    logic   cur_req;

    assign cur_req = (grant == LD_GRANT) ? ld_req : f_req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= IDLE;
            phase <= ISSUE;
        end else begin
            case (grant)
                IDLE: begin
                    phase <= ISSUE;
                    if (ld_req) begin
                        grant <= LD_GRANT;   // loader wins when both ask
                    end else if (f_req) begin
                        grant <= F_GRANT;
                    end
                end
                default: begin
                    case (phase)
                        ISSUE: phase <= RESP;   // sram access this cycle
                        RESP: begin
                            if (!cur_req) begin
                                phase <= RELEASE;
                            end
                        end
                        default: begin
                            grant <= IDLE;  // ack already low here
                            phase <= ISSUE;
                        end
                    endcase
                end
            endcase
        end
    end

    assign mem_en = (grant != IDLE) && (phase == ISSUE);
    assign ld_ack = (grant == LD_GRANT) && (phase == RESP);
    assign f_ack  = (grant == F_GRANT) && (phase == RESP);
    assign f_rdata = rdata;   // stays put, no other read until next grant

    always_comb begin
        if (grant == LD_GRANT) begin
            mem_req = ld_cmd;
        end else begin
            mem_req.we    = 1'b0;
            mem_req.addr  = f_addr;
            mem_req.wdata = '0;
        end
    end

endmodule

/* fetch/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        fetch_start,
    input  logic [isa_pkg::XLEN-1:0]    fetch_pc,
    output logic                        fetch_done,
    output isa_pkg::instr_word_u        fetch_word,
    output logic                        f_req,
    output logic [mem_pkg::MEM_AW-1:0]  f_addr,
    input  logic                        f_ack,
    input  logic [31:0]                 f_rdata
);

    typedef enum logic [1:0] {F_IDLE, F_REQ, F_REL} fetch_state_e;

    fetch_state_e             st;
    logic                     pend;     // start seen during release
    logic [isa_pkg::XLEN-1:0] pc_off;

    assign pc_off = fetch_pc - mem_pkg::MEM_BASE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st         <= F_IDLE;
            f_req      <= 1'b0;
            f_addr     <= '0;
            fetch_done <= 1'b0;
            pend       <= 1'b0;
        end else begin
            fetch_done <= 1'b0;
            if (fetch_start) begin
                pend <= 1'b1;
            end
            case (st)
                F_IDLE: begin
                    if (pend || fetch_start) begin
                        f_req  <= 1'b1;
                        f_addr <= pc_off[mem_pkg::MEM_AW+1:2];  // byte to word
                        pend   <= 1'b0;
                        st     <= F_REQ;
                    end
                end
                F_REQ: begin
                    if (f_ack) begin
                        f_req      <= 1'b0;
                        fetch_done <= 1'b1;
                        st         <= F_REL;
                    end
                end
                default: begin
                    if (!f_ack) begin
                        st <= F_IDLE;   // handshake closed
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == F_REQ && f_ack) begin
            fetch_word <= f_rdata;
        end
    end

endmodule

/* fetch/instr_decoder.sv */
`timescale 1ns/100ps

module instr_decoder (
    input  logic                      clk,
    input  logic                      rst_n,
    input  isa_pkg::instr_word_u      word,
    input  logic                      decode_start,
    output logic                      decode_done,
    output isa_pkg::instr_class_e     iclass,
    output logic [isa_pkg::XLEN-1:0]  imm_j
);

    isa_pkg::instr_class_e    class_c;
    logic [isa_pkg::XLEN-1:0] imm_c;

    always_comb begin
        case (word.ib_fmt.opcode)
            isa_pkg::OP_JAL:    class_c = isa_pkg::JAL;
            isa_pkg::OP_JALR:   class_c = isa_pkg::JALR;
            isa_pkg::OP_BRANCH: class_c = isa_pkg::BRANCH;
            isa_pkg::OP_OP: begin
                if (word.ib_fmt.funct7 == isa_pkg::FUNCT7_MULDIV) begin
                    class_c = isa_pkg::MULDIV;
                end else begin
                    class_c = isa_pkg::PLAIN;
                end
            end
            default:            class_c = isa_pkg::PLAIN;
        endcase
    end

    // reassemble J offset, bit 0 always zero
    assign imm_c = {{11{word.j_fmt.imm20}}, word.j_fmt.imm20, word.j_fmt.imm19_12,
                    word.j_fmt.imm11, word.j_fmt.imm10_1, 1'b0};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            decode_done <= 1'b0;
        end else begin
            decode_done <= decode_start;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_start) begin
            iclass <= class_c;
            imm_j  <= imm_c;
        end
    end

endmodule

/* fetch/pc_sequencer.sv */
`timescale 1ns/100ps

module pc_sequencer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      run,
    output logic                      fetch_start,
    output logic [isa_pkg::XLEN-1:0]  fetch_pc,
    input  logic                      fetch_done,
    input  isa_pkg::instr_word_u      fetch_word,
    output logic                      decode_start,
    input  logic                      decode_done,
    input  isa_pkg::instr_class_e     iclass,
    input  logic [isa_pkg::XLEN-1:0]  imm_j,
    output logic                      issue_req,
    input  logic                      issue_ack,
    output isa_pkg::issue_t           issue,
    input  logic                      resolve_valid,
    input  isa_pkg::resolve_t         resolve,
    input  logic                      md_done
);

    typedef enum logic [2:0] {
        IDLE, FETCH, DECODE, ISSUE, RELEASE, WAIT_EX, WAIT_MD, NEXT
    } seq_state_e;

    seq_state_e               state;
    logic [isa_pkg::XLEN-1:0] pc;
    logic [isa_pkg::XLEN-1:0] next_pc;
    logic                     ex_flag;   // resolve seen for current instr
    logic                     md_flag;
    logic                     clr_flags;
    isa_pkg::resolve_t        ex_res;

    assign fetch_pc  = pc;
    assign clr_flags = (state == DECODE) && decode_done;

    always_comb begin
        case (iclass)
            isa_pkg::JAL:    next_pc = pc + imm_j;
            isa_pkg::JALR,
            isa_pkg::BRANCH: next_pc = ex_res.taken ? ex_res.target : pc + 32'd4;
            default:         next_pc = pc + 32'd4;   // plain and mul/div
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= IDLE;
            pc           <= isa_pkg::RESET_PC;
            fetch_start  <= 1'b0;
            decode_start <= 1'b0;
            issue_req    <= 1'b0;
        end else begin
            fetch_start  <= 1'b0;
            decode_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (run) begin
                        fetch_start <= 1'b1;
                        state       <= FETCH;
                    end
                end
                FETCH: begin
                    if (fetch_done) begin
                        decode_start <= 1'b1;
                        state        <= DECODE;
                    end
                end
                DECODE: begin
                    if (decode_done) begin
                        issue_req <= 1'b1;
                        state     <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (issue_ack) begin
                        issue_req <= 1'b0;
                        state     <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!issue_ack) begin
                        case (iclass)
                            isa_pkg::JALR, isa_pkg::BRANCH: state <= WAIT_EX;
                            isa_pkg::MULDIV:                state <= WAIT_MD;
                            default:                        state <= NEXT;
                        endcase
                    end
                end
                WAIT_EX: if (ex_flag) state <= NEXT;
                WAIT_MD: if (md_flag) state <= NEXT;
                default: begin
                    pc <= next_pc;
                    if (run) begin
                        fetch_start <= 1'b1;   // fetch unit samples the new pc
                        state       <= FETCH;
                    end else begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // completions may land before issue_ack, so latch them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_flag <= 1'b0;
            md_flag <= 1'b0;
        end else begin
            if (resolve_valid) begin
                ex_flag <= 1'b1;
            end else if (clr_flags) begin
                ex_flag <= 1'b0;
            end
            if (md_done) begin
                md_flag <= 1'b1;
            end else if (clr_flags) begin
                md_flag <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            ex_res <= resolve;
        end
        if (clr_flags) begin
            issue.pc    <= pc;
            issue.instr <= fetch_word;
        end
    end

endmodule

/* design/fetch_subsys.sv */
`timescale 1ns/100ps

module fetch_subsys (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              run,
    input  logic              ld_req,
    output logic              ld_ack,
    input  mem_pkg::mem_req_t ld_cmd,
    output logic              issue_req,
    input  logic              issue_ack,
    output isa_pkg::issue_t   issue,
    input  logic              resolve_valid,
    input  isa_pkg::resolve_t resolve,
    input  logic              md_done
);

    mem_pkg::mem_req_t          mem_req;
    logic                       mem_en;
    logic [31:0]                rdata;
    logic                       f_req;
    logic                       f_ack;
    logic [mem_pkg::MEM_AW-1:0] f_addr;
    logic [31:0]                f_rdata;
    logic                       fetch_start;
    logic                       fetch_done;
    logic [isa_pkg::XLEN-1:0]   fetch_pc;
    isa_pkg::instr_word_u       fetch_word;
    logic                       decode_start;
    logic                       decode_done;
    isa_pkg::instr_class_e      iclass;
    logic [isa_pkg::XLEN-1:0]   imm_j;

    sram_model u_sram (
        .clk(clk), .rst_n(rst_n), .mem_req(mem_req), .mem_en(mem_en), .rdata(rdata)
    );

    mem_arbiter u_arb (
        .clk(clk), .rst_n(rst_n),
        .ld_req(ld_req), .ld_cmd(ld_cmd), .ld_ack(ld_ack),
        .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack), .f_rdata(f_rdata),
        .mem_req(mem_req), .mem_en(mem_en), .rdata(rdata)
    );

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n),
        .fetch_start(fetch_start), .fetch_pc(fetch_pc),
        .fetch_done(fetch_done), .fetch_word(fetch_word),
        .f_req(f_req), .f_addr(f_addr), .f_ack(f_ack), .f_rdata(f_rdata)
    );

    instr_decoder u_dec (
        .clk(clk), .rst_n(rst_n), .word(fetch_word),
        .decode_start(decode_start), .decode_done(decode_done),
        .iclass(iclass), .imm_j(imm_j)
    );

    pc_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .run(run),
        .fetch_start(fetch_start), .fetch_pc(fetch_pc),
        .fetch_done(fetch_done), .fetch_word(fetch_word),
        .decode_start(decode_start), .decode_done(decode_done),
        .iclass(iclass), .imm_j(imm_j),
        .issue_req(issue_req), .issue_ack(issue_ack), .issue(issue),
        .resolve_valid(resolve_valid), .resolve(resolve), .md_done(md_done)
    );

endmodule

/* verif/fetch_subsys_tb.sv */
`timescale 1ns/100ps

module fetch_subsys_tb;

    logic              clk;
    logic              rst_n;
    logic              run;
    logic              ld_req;
    logic              ld_ack;
    mem_pkg::mem_req_t ld_cmd;
    logic              issue_req;
    logic              issue_ack;
    isa_pkg::issue_t   issue;
    logic              resolve_valid;
    isa_pkg::resolve_t resolve;
    logic              md_done;

    logic [31:0] vec [0:127];   // image of the input file
    logic [31:0] rng;
    int          n_prog;
    int          n_late;
    int          n_iss;
    int          base_late;
    int          base_rec;
    int          iss_idx = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          issue_errs = 0;
    int          flow_errs = 0;
    int          misc_errs = 0;
    logic        extra_seen = 1'b0;

    fetch_subsys dut0 (
        .clk(clk), .rst_n(rst_n), .run(run),
        .ld_req(ld_req), .ld_ack(ld_ack), .ld_cmd(ld_cmd),
        .issue_req(issue_req), .issue_ack(issue_ack), .issue(issue),
        .resolve_valid(resolve_valid), .resolve(resolve), .md_done(md_done)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout after %0d cycles, issue %0d of %0d never completed",
                     cycles, iss_idx, n_iss);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // J immediate straight from the ISA bit layout
    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    function automatic logic [31:0] predict_next_pc(input logic [31:0] pc,
                                                    input logic [31:0] w,
                                                    input int act,
                                                    input logic [31:0] tgt);
        logic [6:0] op;
        op = w[6:0];
        if (op == isa_pkg::OP_JAL) begin
            return pc + j_offset(w);
        end else if ((op == isa_pkg::OP_JALR || op == isa_pkg::OP_BRANCH) && act == 1) begin
            return tgt;
        end
        return pc + 32'd4;   // plain, mul/div, not taken
    endfunction

    task automatic check_issue(input isa_pkg::issue_t exp, input isa_pkg::issue_t act);
        if (act !== exp) begin
            issue_errs++;
            $display("[ERROR] %0t issue: expected pc=%h instr=%h, got pc=%h instr=%h",
                     $time, exp.pc, exp.instr, act.pc, act.instr);
        end
    endtask

    task automatic check_class_flow(input isa_pkg::resolve_t exp, input isa_pkg::resolve_t act);
        if (act !== exp) begin
            flow_errs++;
            $display("[ERROR] %0t issue.pc flow: expected taken=%b target=%h, got taken=%b target=%h",
                     $time, exp.taken, exp.target, act.taken, act.target);
        end
    endtask

    task automatic write_word(input logic [31:0] byte_addr, input logic [31:0] data);
        logic [31:0] off;
        off = byte_addr - mem_pkg::MEM_BASE;
        @(negedge clk);
        ld_cmd.we    = 1'b1;
        ld_cmd.addr  = off[mem_pkg::MEM_AW+1:2];
        ld_cmd.wdata = data;
        ld_req       = 1'b1;
        while (!ld_ack) @(negedge clk);
        ld_req = 1'b0;
        while (ld_ack) @(negedge clk);
    endtask

    task automatic send_response(input int act, input logic [31:0] tgt);
        if (act == 3) begin
            md_done = 1'b1;
        end else begin
            resolve.taken  = (act == 1);
            resolve.target = tgt;
            resolve_valid  = 1'b1;
        end
        @(negedge clk);
        md_done       = 1'b0;
        resolve_valid = 1'b0;
    endtask

    // check, ack and answer one expected issue
    task automatic serve_issue(input int k);
        int                rec;
        int                act;
        int                dly;
        int                ack_dly;
        int                hold;
        logic              early;
        logic [31:0]       prev_pc;
        logic [31:0]       exp_next;
        isa_pkg::issue_t   exp_iss;
        isa_pkg::resolve_t exp_flow;
        isa_pkg::resolve_t act_flow;
        rec           = base_rec + 5 * k;
        exp_iss.pc    = vec[rec];
        exp_iss.instr = vec[rec + 1];
        act           = vec[rec + 2];
        dly           = vec[rec + 4];
        if (k == 0) begin
            prev_pc  = isa_pkg::RESET_PC - 32'd4;   // reset pc counts as sequential
            exp_next = isa_pkg::RESET_PC;
        end else begin
            prev_pc  = vec[rec - 5];
            exp_next = predict_next_pc(vec[rec - 5], vec[rec - 4], vec[rec - 3], vec[rec - 2]);
        end
        while (!issue_req) @(negedge clk);
        check_issue(exp_iss, issue);
        exp_flow.target = exp_next;
        exp_flow.taken  = (exp_next != prev_pc + 32'd4);
        act_flow.target = issue.pc;
        act_flow.taken  = (issue.pc != prev_pc + 32'd4);
        check_class_flow(exp_flow, act_flow);
        rng     = xorshift32(rng);
        ack_dly = rng[1:0];
        rng     = xorshift32(rng);
        early   = rng[0] && act != 3;   // md_done always after ack so its stall is seen
        if (act != 0 && early) begin
            repeat (dly) @(negedge clk);
            send_response(act, vec[rec + 3]);
        end
        repeat (ack_dly) @(negedge clk);
        issue_ack = 1'b1;
        while (issue_req) @(negedge clk);
        issue_ack = 1'b0;
        if (k == n_iss - 1) begin
            run = 1'b0;
        end
        if (act != 0 && !early) begin
            hold = dly + 12;   // outlasts a full fetch and decode
            repeat (hold) begin
                @(negedge clk);
                if (issue_req) begin
                    misc_errs++;
                    $display("issue at %0t came before the completion of pc %h",
                             $time, exp_iss.pc);
                end
            end
            send_response(act, vec[rec + 3]);
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        run           = 1'b0;
        ld_req        = 1'b0;
        ld_cmd        = '0;
        issue_ack     = 1'b0;
        resolve_valid = 1'b0;
        resolve       = '0;
        md_done       = 1'b0;
        rng           = 32'd69;
        $readmemh("verif/fetch_input.txt", vec);
        n_prog    = vec[0];
        n_late    = vec[1];
        n_iss     = vec[2];
        base_late = 3 + 2 * n_prog;
        base_rec  = base_late + 2 * n_late;
        limit     = 40 * n_prog + 60 * n_iss;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < n_prog; i++) begin
            write_word(vec[3 + 2 * i], vec[4 + 2 * i]);
        end
        @(negedge clk);
        run = 1'b1;
        fork
            begin
                @(negedge clk);   // loader and first fetch meet at the arbiter
                for (int i = 0; i < n_late; i++) begin
                    write_word(vec[base_late + 2 * i], vec[base_late + 1 + 2 * i]);
                end
            end
            begin
                for (iss_idx = 0; iss_idx < n_iss; iss_idx++) begin
                    serve_issue(iss_idx);
                end
            end
        join
        repeat (20) begin
            @(negedge clk);
            if (issue_req && !extra_seen) begin
                extra_seen = 1'b1;
                misc_errs++;
                $display("extra issue at pc %h after the last expected one", issue.pc);
            end
        end
        $display("errors: issue=%0d flow=%0d protocol=%0d", issue_errs, flow_errs, misc_errs);
        if (issue_errs + flow_errs + misc_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* verif/fetch_input.txt */
// header: program words, late loader writes, expected issues
// program and late writes: byte address, word
// issues: pc, instr, action (0 none, 1 taken, 2 not taken, 3 md_done), target, delay
0C 01 0B
80000000 00100093
80000004 0100006F
80000008 00000013
8000000C 00000013
80000010 00200113
80000014 00000663
80000018 00600313
80000020 022081B3
80000024 00209463
80000028 00028067
80000040 00000013
80000044 FCDFF06F
// late write over the nop at 0x40
80000040 00500213
80000000 00100093 0 00000000 0
80000004 0100006F 0 00000000 0
80000014 00000663 1 80000020 2
80000020 022081B3 3 00000000 3
80000024 00209463 2 00000000 1
80000028 00028067 1 80000040 0
80000040 00500213 0 00000000 0
80000044 FCDFF06F 0 00000000 0
80000010 00200113 0 00000000 0
80000014 00000663 2 00000000 2
80000018 00600313 0 00000000 0

/* fetch_subsys.f */
common/isa_pkg.sv
common/mem_pkg.sv
design/sram_model.sv
design/mem_arbiter.sv
fetch/fetch_unit.sv
fetch/instr_decoder.sv
fetch/pc_sequencer.sv
design/fetch_subsys.sv
verif/fetch_subsys_tb.sv
